// ==== aes_axi.f ====
source/aes_axi_pkg.sv
source/aes_sbox.sv
source/axil_slave.sv
source/aes_reg_bank.sv
source/aes_round_engine.sv
source/aes_axi_top.sv
sim/tb_aes_axi.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -f aes_axi.f \
		--top-module tb_aes_axi --Mdir obj_dir -o tb_aes_axi \
	&& { ./obj_dir/tb_aes_axi > sim.log 2>&1 || true; } \
	&& cat sim.log \
	&& grep -q '^\*\*\* TEST PASSED \*\*\*$' sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// ==== sim/tb_aes_axi.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_aes_axi;

	localparam int ADDR_W     = 7;
	localparam int MAX_CYCLES = 3000;
	localparam int MAX_POLLS  = 50;

	logic              S_AXI_ACLK;
	logic              S_AXI_ARESETN;
	logic [ADDR_W-1:0] s_axi_awaddr;
	logic              s_axi_awvalid;
	wire               s_axi_awready;
	logic [31:0]       s_axi_wdata;
	logic [3:0]        s_axi_wstrb;
	logic              s_axi_wvalid;
	wire               s_axi_wready;
	wire  [1:0]        s_axi_bresp;
	wire               s_axi_bvalid;
	logic              s_axi_bready;
	logic [ADDR_W-1:0] s_axi_araddr;
	logic              s_axi_arvalid;
	wire               s_axi_arready;
	wire  [31:0]       s_axi_rdata;
	wire  [1:0]        s_axi_rresp;
	wire               s_axi_rvalid;
	logic              s_axi_rready;

	integer seed;
	int     cycle_count = 0;
	string  test_name;

	aes_axi_top #(
		.ADDR_W (ADDR_W)
	) i_dut (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.s_axi_awaddr  (s_axi_awaddr),
		.s_axi_awvalid (s_axi_awvalid),
		.s_axi_awready (s_axi_awready),
		.s_axi_wdata   (s_axi_wdata),
		.s_axi_wstrb   (s_axi_wstrb),
		.s_axi_wvalid  (s_axi_wvalid),
		.s_axi_wready  (s_axi_wready),
		.s_axi_bresp   (s_axi_bresp),
		.s_axi_bvalid  (s_axi_bvalid),
		.s_axi_bready  (s_axi_bready),
		.s_axi_araddr  (s_axi_araddr),
		.s_axi_arvalid (s_axi_arvalid),
		.s_axi_arready (s_axi_arready),
		.s_axi_rdata   (s_axi_rdata),
		.s_axi_rresp   (s_axi_rresp),
		.s_axi_rvalid  (s_axi_rvalid),
		.s_axi_rready  (s_axi_rready)
	);

	always #50 S_AXI_ACLK = ~S_AXI_ACLK;

	// Watchdog
	always @(posedge S_AXI_ACLK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			stop_with_failure("Timeout, the tests did not finish within the cycle limit");
		end
	end

	////////////////////////////////////////////////////////////
	// Reporting
	////////////////////////////////////////////////////////////

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_value(input string label, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			stop_with_failure($sformatf("Error in %s (%s): expected %08h, actual %08h",
				test_name, label, expected, actual));
		end
	endtask

	////////////////////////////////////////////////////////////
	// Bus tasks
	////////////////////////////////////////////////////////////

	task automatic axi_write(input aes_axi_pkg::reg_idx_t idx, input logic [31:0] data,
		input logic [3:0] strb, input int bready_hold);
		@(negedge S_AXI_ACLK);
		s_axi_awaddr  = ADDR_W'({idx, 2'b00});
		s_axi_awvalid = 1'b1;
		s_axi_wdata   = data;
		s_axi_wstrb   = strb;
		s_axi_wvalid  = 1'b1;
		s_axi_bready  = 1'b0;
		while (!(s_axi_awready && s_axi_wready)) begin
			@(negedge S_AXI_ACLK);
		end
		// Beat transfers on the coming rising edge
		@(negedge S_AXI_ACLK);
		s_axi_awvalid = 1'b0;
		s_axi_wvalid  = 1'b0;
		while (!s_axi_bvalid) begin
			@(negedge S_AXI_ACLK);
		end
		// OKAY is 2'b00
		check_value("write response", 32'h0, {30'b0, s_axi_bresp});
		for (int i = 0; i < bready_hold; i++) begin
			@(negedge S_AXI_ACLK);
			if (!s_axi_bvalid) begin
				stop_with_failure("BVALID dropped while BREADY was still low");
			end
		end
		s_axi_bready = 1'b1;
		@(negedge S_AXI_ACLK);
		s_axi_bready = 1'b0;
	endtask

	task automatic axi_read(input aes_axi_pkg::reg_idx_t idx, input int rready_hold,
		output logic [31:0] data);
		logic [31:0] first;
		@(negedge S_AXI_ACLK);
		s_axi_araddr  = ADDR_W'({idx, 2'b00});
		s_axi_arvalid = 1'b1;
		s_axi_rready  = 1'b0;
		while (!s_axi_arready) begin
			@(negedge S_AXI_ACLK);
		end
		@(negedge S_AXI_ACLK);
		s_axi_arvalid = 1'b0;
		while (!s_axi_rvalid) begin
			@(negedge S_AXI_ACLK);
		end
		check_value("read response", 32'h0, {30'b0, s_axi_rresp});
		first = s_axi_rdata;
		for (int i = 0; i < rready_hold; i++) begin
			@(negedge S_AXI_ACLK);
			if (!s_axi_rvalid) begin
				stop_with_failure("RVALID dropped while RREADY was still low");
			end
			check_value("RDATA while RREADY low", first, s_axi_rdata);
		end
		data = s_axi_rdata;
		s_axi_rready = 1'b1;
		@(negedge S_AXI_ACLK);
		s_axi_rready = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	// Word 0 goes to the lowest index and carries the top bits
	task automatic write_block(input aes_axi_pkg::reg_idx_t base, input logic [127:0] value);
		for (int i = 0; i < 4; i++) begin
			axi_write(base + aes_axi_pkg::reg_idx_t'(i), value[127 - 32*i -: 32], 4'hf, 0);
		end
	endtask

	task automatic check_result(input logic [127:0] expected);
		logic [31:0] got;
		for (int i = 0; i < 4; i++) begin
			axi_read(aes_axi_pkg::REG_RESULT0 + aes_axi_pkg::reg_idx_t'(i), 0, got);
			check_value($sformatf("result word %0d", i), expected[127 - 32*i -: 32], got);
		end
	endtask

	task automatic wait_for_ready();
		logic [31:0] ctrl;
		int          polls;
		ctrl  = '0;
		polls = 0;
		while (!ctrl[31]) begin
			if (polls >= MAX_POLLS) begin
				stop_with_failure("Engine did not report ready within 50 polls of the control word");
			end else begin
				axi_read(aes_axi_pkg::REG_CTRL, 0, ctrl);
				polls++;
			end
		end
		check_value("control word when ready", 32'h8000_0000, ctrl);
	endtask

	function automatic logic [31:0] strobe_mask(input logic [3:0] strb);
		return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
	endfunction

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	// Indices 0 to 22 all read zero out of reset
	task automatic test_reset_state();
		logic [31:0] got;
		test_name = "reset state";
		for (int i = 0; i <= 22; i++) begin
			axi_read(aes_axi_pkg::reg_idx_t'(i), 0, got);
			check_value($sformatf("index %0d", i), 32'h0, got);
		end
	endtask

	task automatic test_strobe_writes();
		aes_axi_pkg::reg_idx_t idx;
		logic [31:0]           old_word;
		logic [31:0]           new_word;
		logic [31:0]           mask;
		logic [31:0]           got;
		logic [3:0]            strb;
		test_name = "byte strobes";
		for (int i = 0; i < 7; i++) begin
			if (i < 4) begin
				idx = aes_axi_pkg::REG_KEY0 + aes_axi_pkg::reg_idx_t'(i);
			end else begin
				idx = aes_axi_pkg::REG_MSG0 + aes_axi_pkg::reg_idx_t'(i - 4);
			end
			old_word = $random(seed);
			new_word = $random(seed);
			strb     = 4'($random(seed));
			// Keep the strobe partial
			if (strb == 4'h0 || strb == 4'hf) begin
				strb = 4'b1001;
			end
			axi_write(idx, old_word, 4'hf, 0);
			axi_write(idx, new_word, strb, 0);
			mask = strobe_mask(strb);
			axi_read(idx, 0, got);
			check_value($sformatf("index %0d strobe %b", idx, strb),
				(new_word & mask) | (old_word & ~mask), got);
		end
		// Dropped indices
		axi_write(5'd5, 32'hffff_ffff, 4'hf, 0);
		axi_write(5'd9, 32'hffff_ffff, 4'hf, 0);
		axi_read(5'd5, 0, got);
		check_value("dropped index 5", 32'h0, got);
		axi_read(5'd9, 0, got);
		check_value("dropped index 9", 32'h0, got);
	endtask

	task automatic test_fips_vector();
		logic [31:0] got;
		test_name = "FIPS-197 example";
		write_block(aes_axi_pkg::REG_KEY0, 128'h000102030405060708090a0b0c0d0e0f);
		write_block(aes_axi_pkg::REG_MSG0, 128'h00112233445566778899aabbccddeeff);
		wait_for_ready();
		check_result(128'h69c4e0d86a7b0430d8cdb78070b4c55a);
		axi_read(aes_axi_pkg::REG_CYCLES, 0, got);
		check_value("cycle counter", 32'd11, got);
	endtask

	task automatic test_zero_vector();
		logic [31:0] got;
		test_name = "all-zero key and block";
		write_block(aes_axi_pkg::REG_KEY0, 128'h0);
		write_block(aes_axi_pkg::REG_MSG0, 128'h0);
		wait_for_ready();
		check_result(128'h66e94bd4ef8a2c3b884cfa59ca342b2e);
		axi_read(aes_axi_pkg::REG_CTRL, 0, got);
		check_value("ready bit", 32'h8000_0000, got);
	endtask

	task automatic test_clear();
		logic [31:0] got;
		test_name = "clear";
		axi_write(aes_axi_pkg::REG_CLEAR, 32'h1, 4'hf, 0);
		axi_read(aes_axi_pkg::REG_CTRL, 0, got);
		check_value("control word", 32'h0, got);
		for (int i = 0; i < 4; i++) begin
			axi_read(aes_axi_pkg::REG_KEY0 + aes_axi_pkg::reg_idx_t'(i), 0, got);
			check_value($sformatf("key word %0d", i), 32'h0, got);
			axi_read(aes_axi_pkg::REG_MSG0 + aes_axi_pkg::reg_idx_t'(i), 0, got);
			check_value($sformatf("block word %0d", i), 32'h0, got);
		end
		axi_read(aes_axi_pkg::REG_CYCLES, 0, got);
		check_value("cycle counter", 32'h0, got);
	endtask

	task automatic test_back_pressure();
		logic [31:0] got;
		test_name = "back-pressure";
		axi_write(aes_axi_pkg::REG_KEY0, 32'h5a3c_96e1, 4'hf, 5);
		axi_read(aes_axi_pkg::REG_KEY0, 5, got);
		check_value("key word 0 readback", 32'h5a3c_96e1, got);
	endtask

	initial begin
		seed          = 32'ha3b5_4cde;
		S_AXI_ACLK    = 1'b0;
		S_AXI_ARESETN = 1'b0;
		s_axi_awaddr  = '0;
		s_axi_awvalid = 1'b0;
		s_axi_wdata   = '0;
		s_axi_wstrb   = '0;
		s_axi_wvalid  = 1'b0;
		s_axi_bready  = 1'b0;
		s_axi_araddr  = '0;
		s_axi_arvalid = 1'b0;
		s_axi_rready  = 1'b0;
		repeat (8) @(negedge S_AXI_ACLK);
		S_AXI_ARESETN = 1'b1;

		test_reset_state();
		test_strobe_writes();
		test_fips_vector();
		test_zero_vector();
		test_clear();
		test_back_pressure();

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/aes_axi_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module aes_axi_top #(
	parameter int ADDR_W = 7
) (
	input  wire                            S_AXI_ACLK,
	input  wire                            S_AXI_ARESETN,
	input  wire  [ADDR_W-1:0]              s_axi_awaddr,
	input  wire                            s_axi_awvalid,
	output logic                           s_axi_awready,
	input  wire  [aes_axi_pkg::DATA_W-1:0] s_axi_wdata,
	input  wire  [aes_axi_pkg::STRB_W-1:0] s_axi_wstrb,
	input  wire                            s_axi_wvalid,
	output logic                           s_axi_wready,
	output logic [1:0]                     s_axi_bresp,
	output logic                           s_axi_bvalid,
	input  wire                            s_axi_bready,
	input  wire  [ADDR_W-1:0]              s_axi_araddr,
	input  wire                            s_axi_arvalid,
	output logic                           s_axi_arready,
	output logic [aes_axi_pkg::DATA_W-1:0] s_axi_rdata,
	output logic [1:0]                     s_axi_rresp,
	output logic                           s_axi_rvalid,
	input  wire                            s_axi_rready
);

	// Register strobes
	logic                           wr_en;
	aes_axi_pkg::reg_idx_t          wr_idx;
	aes_axi_pkg::word_t             wr_data;
	logic [aes_axi_pkg::STRB_W-1:0] wr_strb;
	logic                           rd_en;
	aes_axi_pkg::reg_idx_t          rd_idx;
	aes_axi_pkg::word_t             rd_data;

	// Engine control and data
	logic                start;
	logic                abort;
	logic                ready;
	aes_axi_pkg::block_t key;
	aes_axi_pkg::block_t plaintext;
	aes_axi_pkg::block_t result;

	axil_slave #(
		.ADDR_W (ADDR_W)
	) i_slave (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.s_axi_awaddr  (s_axi_awaddr),
		.s_axi_awvalid (s_axi_awvalid),
		.s_axi_awready (s_axi_awready),
		.s_axi_wdata   (s_axi_wdata),
		.s_axi_wstrb   (s_axi_wstrb),
		.s_axi_wvalid  (s_axi_wvalid),
		.s_axi_wready  (s_axi_wready),
		.s_axi_bresp   (s_axi_bresp),
		.s_axi_bvalid  (s_axi_bvalid),
		.s_axi_bready  (s_axi_bready),
		.s_axi_araddr  (s_axi_araddr),
		.s_axi_arvalid (s_axi_arvalid),
		.s_axi_arready (s_axi_arready),
		.s_axi_rdata   (s_axi_rdata),
		.s_axi_rresp   (s_axi_rresp),
		.s_axi_rvalid  (s_axi_rvalid),
		.s_axi_rready  (s_axi_rready),
		.wr_en         (wr_en),
		.wr_idx        (wr_idx),
		.wr_data       (wr_data),
		.wr_strb       (wr_strb),
		.rd_en         (rd_en),
		.rd_idx        (rd_idx),
		.rd_data       (rd_data)
	);

	aes_round_engine i_engine (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.start         (start),
		.abort         (abort),
		.key           (key),
		.plaintext     (plaintext),
		.ready         (ready),
		.result        (result)
	);

	aes_reg_bank i_regs (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.wr_en         (wr_en),
		.wr_idx        (wr_idx),
		.wr_data       (wr_data),
		.wr_strb       (wr_strb),
		.rd_en         (rd_en),
		.rd_idx        (rd_idx),
		.rd_data       (rd_data),
		.start         (start),
		.abort         (abort),
		.key           (key),
		.plaintext     (plaintext),
		.ready         (ready),
		.result        (result)
	);

endmodule

`default_nettype wire

// ==== source/aes_round_engine.sv ====
`timescale 1ns/10ps
`default_nettype none

module aes_round_engine (
	input  wire                       S_AXI_ACLK,
	input  wire                       S_AXI_ARESETN,
	input  wire                       start,
	input  wire                       abort,
	input  wire  aes_axi_pkg::block_t key,
	input  wire  aes_axi_pkg::block_t plaintext,
	output logic                      ready,
	output aes_axi_pkg::block_t       result
);

	localparam int RND_W = $clog2(aes_axi_pkg::NUM_ROUNDS + 1);

	aes_axi_pkg::block_t state_q;
	aes_axi_pkg::block_t round_key_q;
	logic [RND_W-1:0]    round_q;
	logic [7:0]          rcon_q;
	logic                busy_q;

	wire aes_axi_pkg::block_t sub_bytes;
	wire aes_axi_pkg::word_t  sub_word;
	aes_axi_pkg::word_t       rot_word;
	aes_axi_pkg::word_t       key_temp;
	aes_axi_pkg::block_t      shifted;
	aes_axi_pkg::block_t      mixed;
	aes_axi_pkg::block_t      next_key;
	aes_axi_pkg::block_t      next_state;

	// Multiply by x in GF(2^8)
	function automatic logic [7:0] xtime(input logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	function automatic aes_axi_pkg::word_t mix_column(input aes_axi_pkg::word_t col);
		logic [7:0] a0, a1, a2, a3;
		{a0, a1, a2, a3} = col;
		return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
			a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
			a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
			xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
	endfunction

	////////////////////////////////////////////////////////////
	// Round datapath
	////////////////////////////////////////////////////////////

	// Byte 0 of the state in the top bits, columns of four bytes
	for (genvar i = 0; i < 16; i++) begin : g_sub
		aes_sbox i_sbox (
			.in_byte  (state_q[127 - 8*i -: 8]),
			.out_byte (sub_bytes[127 - 8*i -: 8])
		);
	end

	// ShiftRows then MixColumns, column by column
	always_comb begin
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++) begin
				shifted[127 - 8*(4*c + r) -: 8] = sub_bytes[127 - 8*(4*((c + r) % 4) + r) -: 8];
			end
			mixed[127 - 32*c -: 32] = mix_column(shifted[127 - 32*c -: 32]);
		end
	end

	// Last round has no MixColumns
	assign next_state = ((round_q == RND_W'(aes_axi_pkg::NUM_ROUNDS)) ? shifted : mixed)
		^ next_key;

	////////////////////////////////////////////////////////////
	// Key expansion
	////////////////////////////////////////////////////////////

	assign rot_word = {round_key_q[23:0], round_key_q[31:24]};

	for (genvar k = 0; k < 4; k++) begin : g_key_sub
		aes_sbox i_sbox (
			.in_byte  (rot_word[31 - 8*k -: 8]),
			.out_byte (sub_word[31 - 8*k -: 8])
		);
	end

	assign key_temp = sub_word ^ {rcon_q, 24'h0};

	// Each new word chains onto the one before it
	always_comb begin : p_key_expand
		aes_axi_pkg::word_t w;
		w = key_temp;
		for (int k = 0; k < 4; k++) begin
			w = w ^ round_key_q[127 - 32*k -: 32];
			next_key[127 - 32*k -: 32] = w;
		end
	end

	////////////////////////////////////////////////////////////
	// Control and state registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN || abort) begin
			busy_q  <= 1'b0;
			ready   <= 1'b0;
			round_q <= '0;
		end else if (start) begin
			busy_q  <= 1'b1;
			ready   <= 1'b0;
			round_q <= RND_W'(1);
		end else if (busy_q) begin
			if (round_q == RND_W'(aes_axi_pkg::NUM_ROUNDS)) begin
				busy_q  <= 1'b0;
				ready   <= 1'b1;
				round_q <= '0;
			end else begin
				round_q <= round_q + 1'b1;
			end
		end
	end

	// Initial AddRoundKey on start, one round per busy cycle after
	always_ff @(posedge S_AXI_ACLK) begin
		if (start) begin
			state_q     <= plaintext ^ key;
			round_key_q <= key;
			rcon_q      <= 8'h01;
		end else if (busy_q) begin
			state_q     <= next_state;
			round_key_q <= next_key;
			rcon_q      <= xtime(rcon_q);
		end
	end

	assign result = state_q;

	round_range: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		round_q <= RND_W'(aes_axi_pkg::NUM_ROUNDS))
		else $error("Round counter past the last round");

endmodule

`default_nettype wire

// ==== source/aes_reg_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

module aes_reg_bank (
	input  wire                            S_AXI_ACLK,
	input  wire                            S_AXI_ARESETN,
	input  wire                            wr_en,
	input  wire  aes_axi_pkg::reg_idx_t    wr_idx,
	input  wire  aes_axi_pkg::word_t       wr_data,
	input  wire  [aes_axi_pkg::STRB_W-1:0] wr_strb,
	input  wire                            rd_en,
	input  wire  aes_axi_pkg::reg_idx_t    rd_idx,
	output aes_axi_pkg::word_t             rd_data,
	output logic                           start,
	output logic                           abort,
	output aes_axi_pkg::block_t            key,
	output aes_axi_pkg::block_t            plaintext,
	input  wire                            ready,
	input  wire  aes_axi_pkg::block_t      result
);

	aes_axi_pkg::word_t key_q [4];
	aes_axi_pkg::word_t msg_q [4];
	aes_axi_pkg::word_t cycles_q;
	logic               busy_q;

	function automatic aes_axi_pkg::word_t merge_bytes(
		input aes_axi_pkg::word_t             old_word,
		input aes_axi_pkg::word_t             new_word,
		input logic [aes_axi_pkg::STRB_W-1:0] strb
	);
		aes_axi_pkg::word_t merged;
		merged = old_word;
		for (int b = 0; b < aes_axi_pkg::STRB_W; b++) begin
			if (strb[b]) begin
				merged[8*b +: 8] = new_word[8*b +: 8];
			end
		end
		return merged;
	endfunction

	////////////////////////////////////////////////////////////
	// Key and block registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN || abort) begin
			for (int i = 0; i < 4; i++) begin
				key_q[i] <= '0;
				msg_q[i] <= '0;
			end
		end else if (wr_en) begin
			for (int i = 0; i < 4; i++) begin
				if (int'(wr_idx) == int'(aes_axi_pkg::REG_KEY0) + i) begin
					key_q[i] <= merge_bytes(key_q[i], wr_data, wr_strb);
				end
				if (int'(wr_idx) == int'(aes_axi_pkg::REG_MSG0) + i) begin
					msg_q[i] <= merge_bytes(msg_q[i], wr_data, wr_strb);
				end
			end
		end
	end

	assign key       = {key_q[0], key_q[1], key_q[2], key_q[3]};
	assign plaintext = {msg_q[0], msg_q[1], msg_q[2], msg_q[3]};

	// Strobes follow the write by one cycle
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			start <= 1'b0;
			abort <= 1'b0;
		end else begin
			start <= wr_en && (wr_idx == aes_axi_pkg::REG_MSG_LAST);
			abort <= wr_en && (wr_idx == aes_axi_pkg::REG_CLEAR);
		end
	end

	// Busy from start until ready, the ready cycle still counts
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN || abort) begin
			busy_q   <= 1'b0;
			cycles_q <= '0;
		end else if (start) begin
			busy_q   <= 1'b1;
			cycles_q <= '0;
		end else if (busy_q) begin
			cycles_q <= cycles_q + 1'b1;
			if (ready) begin
				busy_q <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Read mux
	////////////////////////////////////////////////////////////

	always_comb begin
		rd_data = '0;
		if (rd_en) begin
			if (rd_idx == aes_axi_pkg::REG_CTRL) begin
				rd_data[aes_axi_pkg::DATA_W-1] = ready;
			end
			if (rd_idx == aes_axi_pkg::REG_CYCLES) begin
				rd_data = cycles_q;
			end
			for (int i = 0; i < 4; i++) begin
				if (int'(rd_idx) == int'(aes_axi_pkg::REG_KEY0) + i) begin
					rd_data = key_q[i];
				end
				if (int'(rd_idx) == int'(aes_axi_pkg::REG_MSG0) + i) begin
					rd_data = msg_q[i];
				end
				// Ciphertext only once the run has finished
				if (int'(rd_idx) == int'(aes_axi_pkg::REG_RESULT0) + i && ready) begin
					rd_data = result[127 - 32*i -: 32];
				end
			end
		end
	end

	start_abort_excl: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		!(start && abort))
		else $error("Start and abort raised together");

	// A finished run was counted for the full engine latency
	run_length: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		busy_q && ready && !start && !abort
		|-> cycles_q == aes_axi_pkg::word_t'(aes_axi_pkg::ENGINE_LATENCY - 1))
		else $error("Engine finished after an unexpected number of cycles");

endmodule

`default_nettype wire

// ==== source/axil_slave.sv ====
`timescale 1ns/10ps
`default_nettype none

module axil_slave #(
	parameter int ADDR_W = 7
) (
	input  wire                            S_AXI_ACLK,
	input  wire                            S_AXI_ARESETN,
	// Write address
	input  wire  [ADDR_W-1:0]              s_axi_awaddr,
	input  wire                            s_axi_awvalid,
	output logic                           s_axi_awready,
	// Write data
	input  wire  [aes_axi_pkg::DATA_W-1:0] s_axi_wdata,
	input  wire  [aes_axi_pkg::STRB_W-1:0] s_axi_wstrb,
	input  wire                            s_axi_wvalid,
	output logic                           s_axi_wready,
	// Write response
	output logic [1:0]                     s_axi_bresp,
	output logic                           s_axi_bvalid,
	input  wire                            s_axi_bready,
	// Read address
	input  wire  [ADDR_W-1:0]              s_axi_araddr,
	input  wire                            s_axi_arvalid,
	output logic                           s_axi_arready,
	// Read data
	output logic [aes_axi_pkg::DATA_W-1:0] s_axi_rdata,
	output logic [1:0]                     s_axi_rresp,
	output logic                           s_axi_rvalid,
	input  wire                            s_axi_rready,
	// Register strobes
	output logic                           wr_en,
	output aes_axi_pkg::reg_idx_t          wr_idx,
	output aes_axi_pkg::word_t             wr_data,
	output logic [aes_axi_pkg::STRB_W-1:0] wr_strb,
	output logic                           rd_en,
	output aes_axi_pkg::reg_idx_t          rd_idx,
	input  wire  aes_axi_pkg::word_t       rd_data
);

	// Shared by AWREADY and WREADY
	logic aw_ready_q;
	logic accept_wr;
	logic accept_rd;

	////////////////////////////////////////////////////////////
	// Write path
	////////////////////////////////////////////////////////////

	// Address and data together, nothing pending
	assign accept_wr = !aw_ready_q && s_axi_awvalid && s_axi_wvalid && !s_axi_bvalid;

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			aw_ready_q   <= 1'b0;
			s_axi_bvalid <= 1'b0;
		end else begin
			aw_ready_q <= accept_wr;
			if (wr_en) begin
				s_axi_bvalid <= 1'b1;
			end else if (s_axi_bvalid && s_axi_bready) begin
				s_axi_bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (accept_wr) begin
			wr_idx  <= s_axi_awaddr[aes_axi_pkg::ADDR_LSB +: aes_axi_pkg::REG_IDX_W];
			wr_data <= s_axi_wdata;
			wr_strb <= s_axi_wstrb;
		end
	end

	assign s_axi_awready = aw_ready_q;
	assign s_axi_wready  = aw_ready_q;
	assign wr_en         = aw_ready_q && s_axi_awvalid && s_axi_wvalid;
	assign s_axi_bresp   = aes_axi_pkg::RESP_OKAY;

	////////////////////////////////////////////////////////////
	// Read path
	////////////////////////////////////////////////////////////

	assign accept_rd = !s_axi_arready && s_axi_arvalid && !s_axi_rvalid;

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			s_axi_arready <= 1'b0;
			s_axi_rvalid  <= 1'b0;
		end else begin
			s_axi_arready <= accept_rd;
			if (rd_en) begin
				s_axi_rvalid <= 1'b1;
			end else if (s_axi_rvalid && s_axi_rready) begin
				s_axi_rvalid <= 1'b0;
			end
		end
	end

	// Register bank answers in the strobe cycle
	always_ff @(posedge S_AXI_ACLK) begin
		if (accept_rd) begin
			rd_idx <= s_axi_araddr[aes_axi_pkg::ADDR_LSB +: aes_axi_pkg::REG_IDX_W];
		end
		if (rd_en) begin
			s_axi_rdata <= rd_data;
		end
	end

	assign rd_en       = s_axi_arready && s_axi_arvalid;
	assign s_axi_rresp = aes_axi_pkg::RESP_OKAY;

	// Responses wait for the master
	bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
		else $error("BVALID dropped before BREADY");

	rvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata))
		else $error("RVALID or RDATA changed before RREADY");

endmodule

`default_nettype wire

// ==== source/aes_sbox.sv ====
`timescale 1ns/10ps
`default_nettype none

module aes_sbox (
	input  wire  [7:0] in_byte,
	output logic [7:0] out_byte
);

	logic [127:0] row;

	// One table row per high nibble
	always_comb begin
		case (in_byte[7:4])
			4'h0: row = 128'h637c777bf26b6fc53001672bfed7ab76;
			4'h1: row = 128'hca82c97dfa5947f0add4a2af9ca472c0;
			4'h2: row = 128'hb7fd9326363ff7cc34a5e5f171d83115;
			4'h3: row = 128'h04c723c31896059a071280e2eb27b275;
			4'h4: row = 128'h09832c1a1b6e5aa0523bd6b329e32f84;
			4'h5: row = 128'h53d100ed20fcb15b6acbbe394a4c58cf;
			4'h6: row = 128'hd0efaafb434d338545f9027f503c9fa8;
			4'h7: row = 128'h51a3408f929d38f5bcb6da2110fff3d2;
			4'h8: row = 128'hcd0c13ec5f974417c4a77e3d645d1973;
			4'h9: row = 128'h60814fdc222a908846eeb814de5e0bdb;
			4'ha: row = 128'he0323a0a4906245cc2d3ac629195e479;
			4'hb: row = 128'he7c8376d8dd54ea96c56f4ea657aae08;
			4'hc: row = 128'hba78252e1ca6b4c6e8dd741f4bbd8b8a;
			4'hd: row = 128'h703eb5664803f60e613557b986c11d9e;
			4'he: row = 128'he1f8981169d98e949b1e87e9ce5528df;
			4'hf: row = 128'h8ca1890dbfe6426841992d0fb054bb16;
		endcase
	end

	// Low nibble picks the byte, entry 0 sits in the top bits
	assign out_byte = row[127 - 8*in_byte[3:0] -: 8];

endmodule

`default_nettype wire

// ==== source/aes_axi_pkg.sv ====
`default_nettype none

package aes_axi_pkg;

	// Bus geometry
	localparam int DATA_W    = 32;
	localparam int STRB_W    = DATA_W / 8;
	localparam int ADDR_LSB  = 2;
	localparam int REG_IDX_W = 5;

	localparam logic [1:0] RESP_OKAY = 2'b00;

	// AES-128 engine
	localparam int NUM_ROUNDS     = 10;
	localparam int ENGINE_LATENCY = NUM_ROUNDS + 1;

	typedef logic [DATA_W-1:0]    word_t;
	typedef logic [127:0]         block_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	////////////////////////////////////////////////////////////
	// Register map, word indices
	////////////////////////////////////////////////////////////

	localparam reg_idx_t REG_CTRL     = 5'd0;
	// Key words 1 to 4, word 0 is the most significant
	localparam reg_idx_t REG_KEY0     = 5'd1;
	// Block words 13 to 16
	localparam reg_idx_t REG_MSG0     = 5'd13;
	localparam reg_idx_t REG_MSG_LAST = 5'd16;
	localparam reg_idx_t REG_CLEAR    = 5'd17;
	localparam reg_idx_t REG_CYCLES   = 5'd18;
	// Ciphertext words 19 to 22
	localparam reg_idx_t REG_RESULT0  = 5'd19;

endpackage

`default_nettype wire
